// ==== bench/tb_cpu_system.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_system;
	import cpu_pkg::*;

	localparam int HALT_TIMEOUT = 2000;

	logic  Clk;
	logic  arst_n;
	logic  load_en;
	word_t load_addr;
	word_t load_data;
	word_t output_port;
	logic  output_valid;
	word_t num_inst;
	logic  is_halted;

	word_t       image [`MEM_DEPTH];
	word_t       prog [$];
	word_t       exp_out [$];
	word_t       got_out [$];
	int          exp_count;
	int          errors;
	int          checks;
	logic        timed_out;
	logic [31:0] lcg_state;

	cpu_system dut (
		.Clk         (Clk),
		.arst_n      (arst_n),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.output_port (output_port),
		.output_valid(output_valid),
		.num_inst    (num_inst),
		.is_halted   (is_halted)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t alu_word(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		instr_t w;
		w.r.opcode = OP_ALU;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic word_t imm_word(opcode_e op, reg_idx_t rt, reg_idx_t rs, logic [7:0] imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic word_t wwd_word(reg_idx_t rs);
		return alu_word(FN_WWD, 2'd0, rs, 2'd0);
	endfunction

	function automatic word_t halt_word();
		return alu_word(FN_HLT, 2'd0, 2'd0, 2'd0);
	endfunction

	task automatic set_register(reg_idx_t r, word_t v);
		prog.push_back(imm_word(OP_LHI, r, 2'd0, v[15:8]));
		prog.push_back(imm_word(OP_ORI, r, r, v[7:0]));
	endtask

	task automatic check_word(string what, word_t got, word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Sequential reference of the instruction set from address 0 up to HLT
	task automatic run_model();
		word_t  regs [`NUM_REGS];
		word_t  mem [`MEM_DEPTH];
		instr_t w;
		word_t  a;
		word_t  b;
		word_t  sum;
		int     pc;
		logic   done;
		regs = '{default: '0};
		mem = image;
		exp_out.delete();
		exp_count = 0;
		pc = 0;
		done = 1'b0;
		while (!done && pc < `MEM_DEPTH) begin
			w = mem[pc];
			pc++;
			exp_count++;
			a = regs[w.r.rs];
			b = regs[w.r.rt];
			sum = a + {{8{w.i.imm[7]}}, w.i.imm};
			case (w.r.opcode)
				OP_ALU: begin
					case (w.r.funct)
						FN_ADD: regs[w.r.rd] = a + b;
						FN_SUB: regs[w.r.rd] = a - b;
						FN_AND: regs[w.r.rd] = a & b;
						FN_ORR: regs[w.r.rd] = a | b;
						FN_NOT: regs[w.r.rd] = ~a;
						FN_TCP: regs[w.r.rd] = 16'd0 - a;
						FN_SHL: regs[w.r.rd] = {a[14:0], 1'b0};
						FN_SHR: regs[w.r.rd] = {a[15], a[15:1]};
						FN_WWD: exp_out.push_back(a);
						FN_HLT: done = 1'b1;
						default: ;
					endcase
				end
				OP_ADI: regs[w.i.rt] = sum;
				OP_ORI: regs[w.i.rt] = a | {8'h00, w.i.imm};
				OP_LHI: regs[w.i.rt] = {w.i.imm, 8'h00};
				OP_LWD: regs[w.i.rt] = mem[sum[7:0]];
				OP_SWD: mem[sum[7:0]] = b;
				default: ;
			endcase
		end
	endtask

	task automatic run_program(string name);
		int a;
		int cycles;
		if (timed_out)
			return;
		// Program words written over the fill pattern
		for (a = 0; a < `MEM_DEPTH; a++)
			image[a] = {~a[7:0], a[7:0]};
		foreach (prog[i])
			image[i] = prog[i];
		run_model();
		@(posedge Clk);
		arst_n <= 1'b0;
		repeat (8) @(posedge Clk);
		for (a = 0; a < `MEM_DEPTH; a++) begin
			load_en <= 1'b1;
			load_addr <= word_t'(a);
			load_data <= image[a];
			@(posedge Clk);
		end
		load_en <= 1'b0;
		@(posedge Clk);
		arst_n <= 1'b1;
		got_out.delete();
		cycles = 0;
		do begin
			@(negedge Clk);
			if (output_valid)
				got_out.push_back(output_port);
			cycles++;
		end while (!is_halted && cycles < HALT_TIMEOUT);
		if (!is_halted) begin
			$display("Timeout: %s did not halt within %0d cycles", name, HALT_TIMEOUT);
			timed_out = 1'b1;
			return;
		end
		check_word({name, " output count"}, word_t'(got_out.size()), word_t'(exp_out.size()));
		foreach (exp_out[i])
			if (i < got_out.size())
				check_word($sformatf("%s output %0d", name, i), got_out[i], exp_out[i]);
		check_word({name, " num_inst"}, num_inst, word_t'(exp_count));
	endtask

	task automatic alu_operations();
		int f;
		prog.delete();
		set_register(2'd1, 16'h9C35);
		set_register(2'd2, 16'h1234);
		for (f = 0; f < 8; f++) begin
			prog.push_back(alu_word(funct_e'(f[5:0]), 2'd3, 2'd1, 2'd2));
			prog.push_back(wwd_word(2'd3));
		end
		prog.push_back(halt_word());
		run_program("alu operations");
	endtask

	task automatic immediate_operations();
		prog.delete();
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd0, 8'hFB));
		prog.push_back(wwd_word(2'd1));
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd1, 8'h7F));
		prog.push_back(wwd_word(2'd1));
		prog.push_back(imm_word(OP_ORI, 2'd2, 2'd1, 8'h80));
		prog.push_back(wwd_word(2'd2));
		prog.push_back(imm_word(OP_LHI, 2'd3, 2'd2, 8'hA5));
		prog.push_back(wwd_word(2'd3));
		prog.push_back(imm_word(OP_ORI, 2'd3, 2'd3, 8'hF0));
		prog.push_back(imm_word(OP_ADI, 2'd0, 2'd3, 8'h80));
		prog.push_back(wwd_word(2'd0));
		prog.push_back(halt_word());
		run_program("immediates");
	endtask

	task automatic operand_forwarding();
		prog.delete();
		// Distance 1
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd0, 8'h07));
		prog.push_back(alu_word(FN_ADD, 2'd2, 2'd1, 2'd1));
		prog.push_back(wwd_word(2'd2));
		// Distance 2
		prog.push_back(imm_word(OP_ADI, 2'd3, 2'd0, 8'h03));
		prog.push_back(imm_word(OP_ORI, 2'd0, 2'd0, 8'h01));
		prog.push_back(alu_word(FN_SUB, 2'd1, 2'd3, 2'd2));
		prog.push_back(wwd_word(2'd1));
		// Distance 3
		prog.push_back(imm_word(OP_LHI, 2'd2, 2'd0, 8'h11));
		prog.push_back(imm_word(OP_ADI, 2'd3, 2'd3, 8'h05));
		prog.push_back(imm_word(OP_ORI, 2'd0, 2'd0, 8'h20));
		prog.push_back(alu_word(FN_ADD, 2'd0, 2'd2, 2'd1));
		prog.push_back(wwd_word(2'd0));
		prog.push_back(wwd_word(2'd3));
		prog.push_back(halt_word());
		run_program("forwarding");
	endtask

	task automatic store_load_stall();
		prog.delete();
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd0, 8'h40));
		set_register(2'd2, 16'h5A3C);
		prog.push_back(imm_word(OP_SWD, 2'd2, 2'd1, 8'h02));
		prog.push_back(imm_word(OP_LWD, 2'd3, 2'd1, 8'h02));
		prog.push_back(wwd_word(2'd3));
		prog.push_back(imm_word(OP_LWD, 2'd0, 2'd1, 8'h05));
		prog.push_back(alu_word(FN_ADD, 2'd2, 2'd0, 2'd3));
		prog.push_back(wwd_word(2'd2));
		// Loaded word goes straight into a store
		prog.push_back(imm_word(OP_LWD, 2'd3, 2'd1, 8'hFF));
		prog.push_back(imm_word(OP_SWD, 2'd3, 2'd1, 8'h03));
		prog.push_back(imm_word(OP_LWD, 2'd0, 2'd1, 8'h03));
		prog.push_back(wwd_word(2'd0));
		prog.push_back(halt_word());
		run_program("memory and stall");
	endtask

	task automatic halt_behavior();
		word_t held;
		prog.delete();
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd0, 8'h09));
		prog.push_back(wwd_word(2'd1));
		prog.push_back(halt_word());
		prog.push_back(wwd_word(2'd1));
		prog.push_back(imm_word(OP_ADI, 2'd1, 2'd1, 8'h01));
		prog.push_back(wwd_word(2'd1));
		run_program("halt");
		if (timed_out)
			return;
		held = num_inst;
		repeat (20) begin
			@(negedge Clk);
			check_word("is_halted after halt", word_t'(is_halted), 16'd1);
			check_word("output_valid after halt", word_t'(output_valid), 16'd0);
			check_word("num_inst after halt", num_inst, held);
		end
	endtask

	task automatic random_programs();
		logic [31:0] r;
		opcode_e     op;
		int          p;
		int          n;
		for (p = 0; p < 3; p++) begin
			prog.delete();
			for (n = 0; n < 30; n++) begin
				r = next_rand();
				case (r[31:30])
					2'd0, 2'd1: begin
						prog.push_back(alu_word(funct_e'({3'b000, r[26:24]}),
							r[21:20], r[19:18], r[17:16]));
					end
					2'd2: begin
						op = (r[29:28] == 2'd0) ? OP_ADI :
							(r[29:28] == 2'd1) ? OP_ORI : OP_LHI;
						prog.push_back(imm_word(op, r[21:20], r[19:18], r[15:8]));
					end
					default: prog.push_back(wwd_word(r[19:18]));
				endcase
			end
			for (n = 0; n < `NUM_REGS; n++)
				prog.push_back(wwd_word(n[1:0]));
			prog.push_back(halt_word());
			run_program($sformatf("random program %0d", p));
		end
	endtask

	initial begin
		lcg_state = 32'd57;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		arst_n = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;

		alu_operations();
		immediate_operations();
		operand_forwarding();
		store_load_stall();
		halt_behavior();
		random_programs();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width
`define WORD_SIZE 16

`define NUM_REGS 4

// Only the low address bits select a word
`define MEM_DEPTH 256

// First fetch address after reset
`define RESET_PC 0

`endif

// ==== common/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_ALU = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0, FN_SUB = 6'd1, FN_AND = 6'd2, FN_ORR = 6'd3,
		FN_NOT = 6'd4, FN_TCP = 6'd5, FN_SHL = 6'd6, FN_SHR = 6'd7,
		FN_WWD = 6'd28, FN_HLT = 6'd29
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
	} alu_op_e;

	// Operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		funct_e   funct;
	} r_view_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [7:0] imm;
	} i_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
	} instr_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    lhi;
		logic    reg_write;
		logic    dest_is_rt;
		logic    mem_read;
		logic    mem_write;
		logic    is_wwd;
		logic    is_hlt;
	} ctrl_t;

	typedef struct packed {
		logic     valid;
		ctrl_t    ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		word_t    rdata1;
		word_t    rdata2;
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		reg_idx_t dest;
		word_t    result;
		word_t    store_data;
	} ex_mem_t;

	// Data is already the ALU result or the loaded word
	typedef struct packed {
		logic     valid;
		logic     reg_write;
		reg_idx_t dest;
		word_t    data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== cpu/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire cpu_pkg::word_t   a,
	input  wire cpu_pkg::word_t   b,
	input  wire cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t        result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 1'b1;
			ALU_SHL: result = a << 1;
			// Arithmetic shift keeps the sign
			ALU_SHR: result = word_t'($signed(a) >>> 1);
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu/control.sv ====
`timescale 1ns/10ps
`default_nettype none

module control (
	input  wire cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t       ctrl
);
	import cpu_pkg::*;

	always_comb begin
		ctrl = '0;
		case (instr.r.opcode)
			OP_ALU: begin
				case (instr.r.funct)
					FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						// Funct codes 0 to 7 follow the ALU encoding
						ctrl.alu_op = alu_op_e'(instr.r.funct[2:0]);
						ctrl.reg_write = 1'b1;
					end
					FN_WWD: ctrl.is_wwd = 1'b1;
					FN_HLT: ctrl.is_hlt = 1'b1;
					default: ctrl = '0;
				endcase
			end
			OP_ADI, OP_ORI, OP_LHI: begin
				ctrl.alu_op = (instr.r.opcode == OP_ORI) ? ALU_OR : ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.lhi = (instr.r.opcode == OP_LHI);
				ctrl.reg_write = 1'b1;
				ctrl.dest_is_rt = 1'b1;
			end
			OP_LWD: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest_is_rt = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			// Address is rs plus offset and rt carries the store data
			OP_SWD: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu/cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu (
	input  wire logic           Clk,
	input  wire logic           arst_n,
	output cpu_pkg::word_t      inst_addr,
	output logic                inst_read,
	input  wire cpu_pkg::word_t inst_rdata,
	output cpu_pkg::word_t      data_addr,
	output logic                data_read,
	output logic                data_write,
	output cpu_pkg::word_t      data_wdata,
	input  wire cpu_pkg::word_t data_rdata,
	output cpu_pkg::word_t      output_port,
	output logic                output_valid,
	output cpu_pkg::word_t      num_inst,
	output logic                is_halted
);
	import cpu_pkg::*;

	word_t    pc;
	logic     halting;
	logic     halted_q;
	logic     if_id_valid;
	instr_t   if_id_instr;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	mem_wb_t  mem_wb;

	ctrl_t    id_ctrl;
	reg_idx_t id_rs;
	reg_idx_t id_rt;
	reg_idx_t id_dest;
	word_t    id_imm;
	word_t    rf_out1;
	word_t    rf_out2;
	logic     id_hlt;
	logic     stall;
	logic     wb_en;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t    mem_value;
	word_t    src_a;
	word_t    src_b;
	word_t    alu_a;
	word_t    alu_b;
	word_t    alu_result;
	logic     ex_wwd;

	// Decode
	assign id_rs = if_id_instr.r.rs;
	assign id_rt = if_id_instr.r.rt;
	assign id_dest = id_ctrl.dest_is_rt ? if_id_instr.r.rt : if_id_instr.r.rd;
	assign id_hlt = if_id_valid && id_ctrl.is_hlt;

	// Load-use hazard
	assign stall = if_id_valid && id_ex.valid && id_ex.ctrl.mem_read &&
		(id_ex.dest == id_rs || id_ex.dest == id_rt);

	always_comb begin
		if (id_ctrl.lhi)
			id_imm = {if_id_instr.i.imm, {(`WORD_SIZE - 8){1'b0}}};
		else if (id_ctrl.use_imm && id_ctrl.alu_op == ALU_OR)
			id_imm = {{(`WORD_SIZE - 8){1'b0}}, if_id_instr.i.imm};
		else
			id_imm = {{(`WORD_SIZE - 8){if_id_instr.i.imm[7]}}, if_id_instr.i.imm};
	end

	control u_control (
		.instr(if_id_instr),
		.ctrl (id_ctrl)
	);

	assign wb_en = mem_wb.valid && mem_wb.reg_write;

	register_file u_register_file (
		.Clk       (Clk),
		.arst_n    (arst_n),
		.read1     (id_rs),
		.read2     (id_rt),
		.write_reg (mem_wb.dest),
		.write_data(mem_wb.data),
		.write_en  (wb_en),
		.read_out1 (rf_out1),
		.read_out2 (rf_out2)
	);

	// Execute with forwarding
	forwarding_unit u_forwarding_unit (
		.ex_rs        (id_ex.rs),
		.ex_rt        (id_ex.rt),
		.mem_dest     (ex_mem.dest),
		.mem_reg_write(ex_mem.valid && ex_mem.reg_write),
		.wb_dest      (mem_wb.dest),
		.wb_reg_write (wb_en),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

	assign mem_value = ex_mem.mem_read ? data_rdata : ex_mem.result;

	always_comb begin
		case (fwd_a)
			FWD_MEM: src_a = mem_value;
			FWD_WB:  src_a = mem_wb.data;
			default: src_a = id_ex.rdata1;
		endcase
		case (fwd_b)
			FWD_MEM: src_b = mem_value;
			FWD_WB:  src_b = mem_wb.data;
			default: src_b = id_ex.rdata2;
		endcase
	end

	// LHI adds its shifted immediate to zero
	assign alu_a = id_ex.ctrl.lhi ? '0 : src_a;
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : src_b;

	alu u_alu (
		.a     (alu_a),
		.b     (alu_b),
		.op    (id_ex.ctrl.alu_op),
		.result(alu_result)
	);

	assign ex_wwd = id_ex.valid && id_ex.ctrl.is_wwd;
	assign output_valid = ex_wwd;
	assign output_port = ex_wwd ? src_a : '0;
	assign is_halted = halted_q || (id_ex.valid && id_ex.ctrl.is_hlt);

	assign inst_addr = pc;
	assign data_addr = ex_mem.result;
	assign data_read = ex_mem.valid && ex_mem.mem_read;
	assign data_write = ex_mem.valid && ex_mem.mem_write;
	assign data_wdata = ex_mem.store_data;

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= word_t'(`RESET_PC);
			inst_read <= 1'b0;
			halting <= 1'b0;
			halted_q <= 1'b0;
			num_inst <= '0;
			if_id_valid <= 1'b0;
			if_id_instr <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			inst_read <= 1'b1;

			// Fetch stops for good once HLT leaves decode
			if (!stall) begin
				if (inst_read && !halting && !id_hlt)
					pc <= pc + 1'b1;
				if_id_valid <= inst_read && !halting && !id_hlt;
				if_id_instr <= inst_rdata;
				if (id_hlt)
					halting <= 1'b1;
			end

			id_ex <= '0;
			if (!stall && if_id_valid) begin
				id_ex.valid <= 1'b1;
				id_ex.ctrl <= id_ctrl;
				id_ex.rs <= id_rs;
				id_ex.rt <= id_rt;
				id_ex.dest <= id_dest;
				id_ex.rdata1 <= rf_out1;
				id_ex.rdata2 <= rf_out2;
				id_ex.imm <= id_imm;
				num_inst <= num_inst + 1'b1;
			end

			if (id_ex.valid && id_ex.ctrl.is_hlt)
				halted_q <= 1'b1;

			ex_mem.valid <= id_ex.valid;
			ex_mem.reg_write <= id_ex.ctrl.reg_write;
			ex_mem.mem_read <= id_ex.ctrl.mem_read;
			ex_mem.mem_write <= id_ex.ctrl.mem_write;
			ex_mem.dest <= id_ex.dest;
			ex_mem.result <= alu_result;
			ex_mem.store_data <= src_b;

			mem_wb.valid <= ex_mem.valid;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.dest <= ex_mem.dest;
			mem_wb.data <= mem_value;
		end
	end

endmodule

`default_nettype wire

// ==== cpu/forwarding_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit (
	input  wire cpu_pkg::reg_idx_t ex_rs,
	input  wire cpu_pkg::reg_idx_t ex_rt,
	input  wire cpu_pkg::reg_idx_t mem_dest,
	input  wire logic              mem_reg_write,
	input  wire cpu_pkg::reg_idx_t wb_dest,
	input  wire logic              wb_reg_write,
	output cpu_pkg::fwd_sel_e      fwd_a,
	output cpu_pkg::fwd_sel_e      fwd_b
);
	import cpu_pkg::*;

	// Newest producer wins
	function automatic fwd_sel_e pick(
		reg_idx_t src,
		reg_idx_t m_dest,
		logic     m_write,
		reg_idx_t w_dest,
		logic     w_write
	);
		if (m_write && m_dest == src)
			return FWD_MEM;
		if (w_write && w_dest == src)
			return FWD_WB;
		return FWD_RF;
	endfunction

	assign fwd_a = pick(ex_rs, mem_dest, mem_reg_write, wb_dest, wb_reg_write);
	assign fwd_b = pick(ex_rt, mem_dest, mem_reg_write, wb_dest, wb_reg_write);

endmodule

`default_nettype wire

// ==== cpu/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module register_file (
	input  wire logic              Clk,
	input  wire logic              arst_n,
	input  wire cpu_pkg::reg_idx_t read1,
	input  wire cpu_pkg::reg_idx_t read2,
	input  wire cpu_pkg::reg_idx_t write_reg,
	input  wire cpu_pkg::word_t    write_data,
	input  wire logic              write_en,
	output cpu_pkg::word_t         read_out1,
	output cpu_pkg::word_t         read_out2
);
	import cpu_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n)
			regs <= '{default: '0};
		else if (write_en)
			regs[write_reg] <= write_data;
	end

	// Write-through so decode sees the value retiring this cycle
	assign read_out1 = (write_en && write_reg == read1) ? write_data : regs[read1];
	assign read_out2 = (write_en && write_reg == read2) ? write_data : regs[read2];

endmodule

`default_nettype wire

// ==== rtl/cpu_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_system (
	input  wire logic           Clk,
	input  wire logic           arst_n,
	input  wire logic           load_en,
	input  wire cpu_pkg::word_t load_addr,
	input  wire cpu_pkg::word_t load_data,
	output cpu_pkg::word_t      output_port,
	output logic                output_valid,
	output cpu_pkg::word_t      num_inst,
	output logic                is_halted
);
	import cpu_pkg::*;

	word_t inst_addr;
	word_t inst_rdata;
	logic  inst_read;
	word_t data_addr;
	word_t data_wdata;
	word_t data_rdata;
	logic  data_read;
	logic  data_write;

	cpu u_cpu (
		.Clk         (Clk),
		.arst_n      (arst_n),
		.inst_addr   (inst_addr),
		.inst_read   (inst_read),
		.inst_rdata  (inst_rdata),
		.data_addr   (data_addr),
		.data_read   (data_read),
		.data_write  (data_write),
		.data_wdata  (data_wdata),
		.data_rdata  (data_rdata),
		.output_port (output_port),
		.output_valid(output_valid),
		.num_inst    (num_inst),
		.is_halted   (is_halted)
	);

	memory u_memory (
		.Clk       (Clk),
		.inst_addr (inst_addr),
		.inst_read (inst_read),
		.inst_rdata(inst_rdata),
		.data_addr (data_addr),
		.data_read (data_read),
		.data_write(data_write),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

endmodule

`default_nettype wire

// ==== rtl/memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module memory (
	input  wire logic           Clk,
	input  wire cpu_pkg::word_t inst_addr,
	input  wire logic           inst_read,
	output cpu_pkg::word_t      inst_rdata,
	input  wire cpu_pkg::word_t data_addr,
	input  wire logic           data_read,
	input  wire logic           data_write,
	input  wire cpu_pkg::word_t data_wdata,
	output cpu_pkg::word_t      data_rdata,
	input  wire logic           load_en,
	input  wire cpu_pkg::word_t load_addr,
	input  wire cpu_pkg::word_t load_data
);
	import cpu_pkg::*;

	localparam int ADDR_W = $clog2(`MEM_DEPTH);

	word_t mem [`MEM_DEPTH];

	assign inst_rdata = inst_read ? mem[inst_addr[ADDR_W-1:0]] : '0;
	assign data_rdata = data_read ? mem[data_addr[ADDR_W-1:0]] : '0;

	// Load port has priority over the data port
	always_ff @(posedge Clk) begin
		if (load_en)
			mem[load_addr[ADDR_W-1:0]] <= load_data;
		else if (data_write)
			mem[data_addr[ADDR_W-1:0]] <= data_wdata;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/cpu_pkg.sv
cpu/alu.sv
cpu/control.sv
cpu/forwarding_unit.sv
cpu/register_file.sv
cpu/cpu.sv
rtl/memory.sv
rtl/cpu_system.sv
bench/tb_cpu_system.sv
